// File: vlog.f
+incdir+testbench
common/ex_pkg.sv
logic/operand_forward.sv
logic/alu.sv
logic/branch_unit.sv
muldiv/muldiv.sv
logic/ex_stage.sv
testbench/tb_ex_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ex_stage -f vlog.f

out=$(./obj_dir/Vtb_ex_stage 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^test passed$"; then
    exit 0
fi
exit 1

// File: testbench/ex_model.svh
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// Load data from the memory stage, slot 1 is the younger one
function automatic logic [XLEN-1:0] forward_operand(
    input logic [REG_AW-1:0] ra,
    input logic [XLEN-1:0]   dispatch_val,
    input logic              we0,
    input logic              ld0,
    input logic [REG_AW-1:0] a0,
    input logic [XLEN-1:0]   d0,
    input logic              we1,
    input logic              ld1,
    input logic [REG_AW-1:0] a1,
    input logic [XLEN-1:0]   d1
);
    if (ra == '0) return dispatch_val;
    if (we1 && ld1 && a1 == ra) return d1;
    if (we0 && ld0 && a0 == ra) return d0;
    return dispatch_val;
endfunction

function automatic logic is_long_op(alu_op_e op);
    return op inside {OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
endfunction

function automatic logic [XLEN-1:0] muldiv_value(alu_op_e op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
    logic signed [63:0] sp;
    logic [63:0]        up;
    logic               min_by_neg1;
    sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    up = {32'b0, a} * {32'b0, b};
    min_by_neg1 = (a == 32'h8000_0000) && (b == '1);
    case (op)
        OP_MUL:   return sp[31:0];
        OP_MULH:  return sp[63:32];
        OP_MULHU: return up[63:32];
        OP_DIV, OP_MOD: begin
            // Corner cases first, the generic divide never sees them
            if (b == '0) return (op == OP_DIV) ? '1 : a;
            if (min_by_neg1) return (op == OP_DIV) ? a : '0;
            if (op == OP_DIV) return $signed(a) / $signed(b);
            return $signed(a) % $signed(b);
        end
        OP_DIVU: return (b == '0) ? '1 : a / b;
        OP_MODU: return (b == '0) ? a : a % b;
        default: return '0;
    endcase
endfunction

function automatic logic [XLEN-1:0] wdata_of(alu_op_e op, logic [XLEN-1:0] s1,
                                             logic [XLEN-1:0] s2, logic [XLEN-1:0] pc);
    case (op)
        OP_OR:          return s1 | s2;
        OP_AND:         return s1 & s2;
        OP_XOR:         return s1 ^ s2;
        OP_NOR:         return ~(s1 | s2);
        OP_SLL:         return s1 << s2[4:0];
        OP_SRL:         return s1 >> s2[4:0];
        OP_SRA:         return $signed(s1) >>> s2[4:0];
        OP_ADD:         return s1 + s2;
        OP_SUB:         return s1 - s2;
        OP_SLT:         return {31'b0, $signed(s1) < $signed(s2)};
        OP_SLTU:        return {31'b0, s1 < s2};
        OP_LUI:         return s2;
        OP_PCADD:       return pc + s2;
        OP_BL, OP_JIRL: return pc + 32'd4;
        default:        return is_long_op(op) ? muldiv_value(op, s1, s2) : '0;
    endcase
endfunction

function automatic logic branch_taken(alu_op_e op, logic [XLEN-1:0] s1, logic [XLEN-1:0] r2);
    case (op)
        OP_B, OP_BL, OP_JIRL: return 1'b1;
        OP_BEQ:               return s1 == r2;
        OP_BNE:               return s1 != r2;
        OP_BLT:               return $signed(s1) < $signed(r2);
        OP_BGE:               return $signed(s1) >= $signed(r2);
        OP_BLTU:              return s1 < r2;
        OP_BGEU:              return s1 >= r2;
        default:              return 1'b0;
    endcase
endfunction

function automatic logic [XLEN-1:0] branch_dest(alu_op_e op, logic [XLEN-1:0] pc,
                                                logic [XLEN-1:0] s1, logic [XLEN-1:0] imm);
    case (op)
        OP_JIRL: return s1 + imm;
        OP_B, OP_BL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: return pc + imm;
        default: return '0;
    endcase
endfunction

`endif

// File: testbench/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

    import ex_pkg::*;

    `include "ex_model.svh"

    logic              clk;
    logic              reset_i;
    alu_op_e           aluop_i;
    logic [XLEN-1:0]   pc_i, oprand1_i, oprand2_i, imm_i;
    logic              use_imm_i, wreg_i;
    logic [REG_AW-1:0] read_addr1_i, read_addr2_i, waddr_i;
    logic              fwd0_we_i, fwd0_load_i, fwd1_we_i, fwd1_load_i;
    logic [REG_AW-1:0] fwd0_addr_i, fwd1_addr_i;
    logic [XLEN-1:0]   fwd0_data_i, fwd1_data_i;
    logic              wreg_o, branch_o, stall_o;
    logic [REG_AW-1:0] waddr_o;
    logic [XLEN-1:0]   wdata_o, mem_addr_o, branch_target_o;

    ex_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "value check failed");
        end
    endtask

    // Biased toward the values that break arithmetic
    function automatic logic [XLEN-1:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return $urandom_range(0, 15);
            default: return $urandom();
        endcase
    endfunction

    task automatic idle_inputs();
        aluop_i      <= OP_NOP;
        pc_i         <= '0;
        oprand1_i    <= '0;
        oprand2_i    <= '0;
        imm_i        <= '0;
        use_imm_i    <= 1'b0;
        read_addr1_i <= '0;
        read_addr2_i <= '0;
        wreg_i       <= 1'b0;
        waddr_i      <= '0;
        fwd0_we_i    <= 1'b0;
        fwd0_load_i  <= 1'b0;
        fwd0_addr_i  <= '0;
        fwd0_data_i  <= '0;
        fwd1_we_i    <= 1'b0;
        fwd1_load_i  <= 1'b0;
        fwd1_addr_i  <= '0;
        fwd1_data_i  <= '0;
    endtask

    task automatic randomize_inputs();
        aluop_i      <= alu_op_e'(6'($urandom_range(0, 30)));
        pc_i         <= $urandom() & 32'hffff_fffc;
        oprand1_i    <= pick_operand();
        oprand2_i    <= pick_operand();
        imm_i        <= pick_operand();
        use_imm_i    <= 1'($urandom_range(0, 1));
        // Small register range so forwarding hits often
        read_addr1_i <= 5'($urandom_range(0, 3));
        read_addr2_i <= 5'($urandom_range(0, 3));
        wreg_i       <= 1'($urandom_range(0, 1));
        waddr_i      <= 5'($urandom());
        fwd0_we_i    <= 1'($urandom_range(0, 1));
        fwd0_load_i  <= 1'($urandom_range(0, 1));
        fwd0_addr_i  <= 5'($urandom_range(0, 3));
        fwd0_data_i  <= pick_operand();
        fwd1_we_i    <= 1'($urandom_range(0, 1));
        fwd1_load_i  <= 1'($urandom_range(0, 1));
        fwd1_addr_i  <= 5'($urandom_range(0, 3));
        fwd1_data_i  <= pick_operand();
    endtask

    task automatic check_outputs();
        logic [XLEN-1:0] s1, r2, s2;
        int unsigned     waited;
        @(negedge clk);
        s1 = forward_operand(read_addr1_i, oprand1_i,
                             fwd0_we_i, fwd0_load_i, fwd0_addr_i, fwd0_data_i,
                             fwd1_we_i, fwd1_load_i, fwd1_addr_i, fwd1_data_i);
        r2 = forward_operand(read_addr2_i, oprand2_i,
                             fwd0_we_i, fwd0_load_i, fwd0_addr_i, fwd0_data_i,
                             fwd1_we_i, fwd1_load_i, fwd1_addr_i, fwd1_data_i);
        s2 = use_imm_i ? imm_i : r2;
        waited = 0;
        if (is_long_op(aluop_i)) begin
            check_equal(32'(stall_o), 32'd1, "stall_o raised for multiply/divide");
            while (stall_o) begin
                check_equal(32'(wreg_o), 32'd0, "wreg_o masked during stall");
                if (waited == 100) begin
                    $display("multiply/divide never finished");
                    $display("test failed");
                    $fatal(1, "stall timeout");
                end
                @(negedge clk);
                waited++;
            end
        end else begin
            check_equal(32'(stall_o), 32'd0, "stall_o low for single-cycle op");
        end
        check_equal(wdata_o, wdata_of(aluop_i, s1, s2, pc_i),
                    $sformatf("wdata_o for %s", aluop_i.name()));
        check_equal(mem_addr_o, s1 + imm_i, "mem_addr_o");
        check_equal(32'(branch_o), 32'(branch_taken(aluop_i, s1, r2)),
                    $sformatf("branch_o for %s", aluop_i.name()));
        check_equal(branch_target_o, branch_dest(aluop_i, pc_i, s1, imm_i),
                    $sformatf("branch_target_o for %s", aluop_i.name()));
        check_equal(32'(wreg_o), 32'(wreg_i), "wreg_o");
        check_equal(32'(waddr_o), 32'(waddr_i), "waddr_o");
    endtask

    task automatic issue_op(input alu_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        @(posedge clk);
        randomize_inputs();
        aluop_i   <= op;
        oprand1_i <= a;
        oprand2_i <= b;
        use_imm_i <= 1'b0;
        wreg_i    <= 1'b1;
        fwd0_we_i <= 1'b0;
        fwd1_we_i <= 1'b0;
        check_outputs();
    endtask

    task automatic forward_case(input logic [REG_AW-1:0] ra, input logic we0, input logic ld0,
                                input logic we1, input logic ld1);
        @(posedge clk);
        randomize_inputs();
        aluop_i      <= OP_ADD;
        use_imm_i    <= 1'b0;
        read_addr1_i <= ra;
        read_addr2_i <= ra;
        fwd0_addr_i  <= ra;
        fwd1_addr_i  <= ra;
        fwd0_we_i    <= we0;
        fwd0_load_i  <= ld0;
        fwd1_we_i    <= we1;
        fwd1_load_i  <= ld1;
        // Distinct values so every source gives its own sum
        oprand1_i    <= 32'h0000_0101;
        oprand2_i    <= 32'h0000_0202;
        fwd0_data_i  <= 32'h0000_1000;
        fwd1_data_i  <= 32'h0002_0000;
        check_outputs();
    endtask

    initial begin
        void'($urandom(32'hd224_27a3));
        reset_i <= 1'b1;
        idle_inputs();
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;

        // Divide corners
        issue_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        issue_op(OP_MOD, 32'h8000_0000, 32'hffff_ffff);
        issue_op(OP_DIV, 32'h1234_5678, 32'h0);
        issue_op(OP_MOD, 32'hfedc_ba98, 32'h0);
        issue_op(OP_DIVU, 32'hdead_beef, 32'h0);
        issue_op(OP_MODU, 32'hdead_beef, 32'h0);
        issue_op(OP_MOD, 32'hffff_fff9, 32'd2);

        // Back to back, then straight into a single-cycle op
        issue_op(OP_MULH, 32'h8000_0000, 32'h8000_0000);
        issue_op(OP_MULHU, 32'hffff_ffff, 32'hffff_ffff);
        issue_op(OP_MUL, 32'hffff_fffd, 32'd7);
        issue_op(OP_ADD, 32'h0000_0005, 32'h0000_0003);

        // Slot priority, non-load and disabled slots, r0
        forward_case(5'd3, 1'b1, 1'b1, 1'b1, 1'b1);
        forward_case(5'd3, 1'b1, 1'b1, 1'b0, 1'b1);
        forward_case(5'd3, 1'b1, 1'b1, 1'b1, 1'b0);
        forward_case(5'd3, 1'b1, 1'b0, 1'b0, 1'b0);
        forward_case(5'd0, 1'b1, 1'b1, 1'b1, 1'b1);

        repeat (400) begin
            @(posedge clk);
            randomize_inputs();
            check_outputs();
        end

        $display("test passed");
        $finish;
    end

endmodule

// File: logic/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                      clk,
    input  logic                      reset_i,
    input  ex_pkg::alu_op_e           aluop_i,
    input  logic [ex_pkg::XLEN-1:0]   pc_i,
    input  logic [ex_pkg::XLEN-1:0]   oprand1_i,
    input  logic [ex_pkg::XLEN-1:0]   oprand2_i,
    input  logic [ex_pkg::XLEN-1:0]   imm_i,
    input  logic                      use_imm_i,
    input  logic [ex_pkg::REG_AW-1:0] read_addr1_i,
    input  logic [ex_pkg::REG_AW-1:0] read_addr2_i,
    input  logic                      wreg_i,
    input  logic [ex_pkg::REG_AW-1:0] waddr_i,
    input  logic                      fwd0_we_i,
    input  logic                      fwd0_load_i,
    input  logic [ex_pkg::REG_AW-1:0] fwd0_addr_i,
    input  logic [ex_pkg::XLEN-1:0]   fwd0_data_i,
    input  logic                      fwd1_we_i,
    input  logic                      fwd1_load_i,
    input  logic [ex_pkg::REG_AW-1:0] fwd1_addr_i,
    input  logic [ex_pkg::XLEN-1:0]   fwd1_data_i,
    output logic                      wreg_o,
    output logic [ex_pkg::REG_AW-1:0] waddr_o,
    output logic [ex_pkg::XLEN-1:0]   wdata_o,
    output logic [ex_pkg::XLEN-1:0]   mem_addr_o,
    output logic                      branch_o,
    output logic [ex_pkg::XLEN-1:0]   branch_target_o,
    output logic                      stall_o
);

    import ex_pkg::*;

    logic [XLEN-1:0] src1, src2, rs2;
    logic [XLEN-1:0] muldiv_result;
    logic            muldiv_op, muldiv_ready, muldiv_finished;
    logic            muldiv_start, muldiv_ack;

    operand_forward u_fwd (
        .oprand1_i    (oprand1_i),
        .oprand2_i    (oprand2_i),
        .imm_i        (imm_i),
        .use_imm_i    (use_imm_i),
        .read_addr1_i (read_addr1_i),
        .read_addr2_i (read_addr2_i),
        .fwd0_we_i    (fwd0_we_i),
        .fwd0_load_i  (fwd0_load_i),
        .fwd0_addr_i  (fwd0_addr_i),
        .fwd0_data_i  (fwd0_data_i),
        .fwd1_we_i    (fwd1_we_i),
        .fwd1_load_i  (fwd1_load_i),
        .fwd1_addr_i  (fwd1_addr_i),
        .fwd1_data_i  (fwd1_data_i),
        .src1_o       (src1),
        .src2_o       (src2),
        .rs2_o        (rs2)
    );

    alu u_alu (
        .aluop_i         (aluop_i),
        .src1_i          (src1),
        .src2_i          (src2),
        .pc_i            (pc_i),
        .muldiv_result_i (muldiv_result),
        .wdata_o         (wdata_o)
    );

    branch_unit u_branch (
        .aluop_i  (aluop_i),
        .pc_i     (pc_i),
        .src1_i   (src1),
        .rs2_i    (rs2),
        .imm_i    (imm_i),
        .branch_o (branch_o),
        .target_o (branch_target_o)
    );

    // Start once per op, ack while the op is still held by dispatch
    assign muldiv_op    = is_muldiv(aluop_i);
    assign muldiv_start = muldiv_op & muldiv_ready & ~muldiv_finished;
    assign muldiv_ack   = muldiv_op & muldiv_finished;

    muldiv u_muldiv (
        .clk        (clk),
        .reset_i    (reset_i),
        .start_i    (muldiv_start),
        .mode_i     (muldiv_mode_of(aluop_i)),
        .rs0_i      (src1),
        .rs1_i      (src2),
        .ack_i      (muldiv_ack),
        .ready_o    (muldiv_ready),
        .finished_o (muldiv_finished),
        .result_o   (muldiv_result)
    );

    assign stall_o    = muldiv_op & ~muldiv_finished;
    assign wreg_o     = wreg_i & ~stall_o;
    assign waddr_o    = waddr_i;
    assign mem_addr_o = src1 + imm_i;

    // Dispatch holds the op, so only a finish can release the stall
    a_stall_release: assert property (@(posedge clk) disable iff (reset_i)
        $fell(stall_o) |-> muldiv_finished);

endmodule

// File: muldiv/muldiv.sv
`timescale 1ns/1ps

module muldiv (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    start_i,
    input  ex_pkg::muldiv_mode_e    mode_i,
    input  logic [ex_pkg::XLEN-1:0] rs0_i,
    input  logic [ex_pkg::XLEN-1:0] rs1_i,
    input  logic                    ack_i,
    output logic                    ready_o,
    output logic                    finished_o,
    output logic [ex_pkg::XLEN-1:0] result_o
);

    import ex_pkg::*;

    typedef enum logic [1:0] {IDLE, RUN, DONE} state_e;

    state_e          state_q;
    logic [5:0]      cnt_q;
    muldiv_mode_e    mode_q;
    logic [XLEN-1:0] hi_q, lo_q, opnd_q, result_q;
    logic            neg_q, rem_neg_q, zero_q;

    logic            signed_mode, a_neg, b_neg, is_div;
    logic [XLEN-1:0] a_mag, b_mag;
    logic [XLEN:0]   mul_sum, div_shift, div_diff;
    logic [2*XLEN-1:0] prod, prod_s;
    logic [XLEN-1:0] quo, rem, fix_result;

    assign signed_mode = mode_i inside {MD_MUL, MD_MULH, MD_DIV, MD_MOD};
    assign a_neg = signed_mode & rs0_i[XLEN-1];
    assign b_neg = signed_mode & rs1_i[XLEN-1];
    assign a_mag = a_neg ? -rs0_i : rs0_i;
    assign b_mag = b_neg ? -rs1_i : rs1_i;

    assign is_div = mode_q[2];

    // One step of shift-add multiply, or restoring divide
    assign mul_sum   = lo_q[0] ? ({1'b0, hi_q} + {1'b0, opnd_q}) : {1'b0, hi_q};
    assign div_shift = {hi_q, lo_q[XLEN-1]};
    assign div_diff  = div_shift - {1'b0, opnd_q};

    // Sign fix-up
    assign prod   = {hi_q, lo_q};
    assign prod_s = neg_q ? -prod : prod;
    assign quo    = zero_q ? '1 : (neg_q ? -lo_q : lo_q);
    assign rem    = rem_neg_q ? -hi_q : hi_q;

    always_comb begin
        if (is_div) begin
            fix_result = mode_q[1] ? rem : quo;
        end else begin
            fix_result = (mode_q == MD_MUL) ? prod_s[XLEN-1:0] : prod_s[2*XLEN-1:XLEN];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        cnt_q   <= '0;
                    end
                end
                RUN: begin
                    cnt_q <= cnt_q + 6'd1;
                    if (cnt_q[5]) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            mode_q    <= mode_i;
            neg_q     <= a_neg ^ b_neg;
            rem_neg_q <= a_neg;
            zero_q    <= (rs1_i == '0);
            hi_q      <= '0;
            // Divide shifts the dividend out of lo, multiply the multiplier
            lo_q      <= mode_i[2] ? a_mag : b_mag;
            opnd_q    <= mode_i[2] ? b_mag : a_mag;
        end else if (state_q == RUN && !cnt_q[5]) begin
            if (is_div) begin
                if (!div_diff[XLEN]) begin
                    hi_q <= div_diff[XLEN-1:0];
                    lo_q <= {lo_q[XLEN-2:0], 1'b1};
                end else begin
                    hi_q <= div_shift[XLEN-1:0];
                    lo_q <= {lo_q[XLEN-2:0], 1'b0};
                end
            end else begin
                hi_q <= mul_sum[XLEN:1];
                lo_q <= {mul_sum[0], lo_q[XLEN-1:1]};
            end
        end else if (state_q == RUN) begin
            result_q <= fix_result;
        end
    end

    assign ready_o    = (state_q == IDLE);
    assign finished_o = (state_q == DONE);
    assign result_o   = result_q;

    a_start_idle: assert property (@(posedge clk) disable iff (reset_i)
        start_i |-> state_q == IDLE);

    a_finish_hold: assert property (@(posedge clk) disable iff (reset_i)
        finished_o && !ack_i |=> finished_o);

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  ex_pkg::alu_op_e         aluop_i,
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    input  logic [ex_pkg::XLEN-1:0] src1_i,
    input  logic [ex_pkg::XLEN-1:0] rs2_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    output logic                    branch_o,
    output logic [ex_pkg::XLEN-1:0] target_o
);

    import ex_pkg::*;

    logic [XLEN-1:0] pc_rel;

    assign pc_rel = pc_i + imm_i;

    always_comb begin
        branch_o = 1'b0;
        target_o = '0;
        case (aluop_i)
            OP_B, OP_BL: begin
                branch_o = 1'b1;
                target_o = pc_rel;
            end
            OP_JIRL: begin
                branch_o = 1'b1;
                target_o = src1_i + imm_i;
            end
            // Conditional branches give the target even when not taken
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                target_o = pc_rel;
                case (aluop_i)
                    OP_BEQ:  branch_o = (src1_i == rs2_i);
                    OP_BNE:  branch_o = (src1_i != rs2_i);
                    OP_BLT:  branch_o = ($signed(src1_i) < $signed(rs2_i));
                    OP_BGE:  branch_o = ($signed(src1_i) >= $signed(rs2_i));
                    OP_BLTU: branch_o = (src1_i < rs2_i);
                    OP_BGEU: branch_o = (src1_i >= rs2_i);
                    default: branch_o = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  ex_pkg::alu_op_e         aluop_i,
    input  logic [ex_pkg::XLEN-1:0] src1_i,
    input  logic [ex_pkg::XLEN-1:0] src2_i,
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    input  logic [ex_pkg::XLEN-1:0] muldiv_result_i,
    output logic [ex_pkg::XLEN-1:0] wdata_o
);

    import ex_pkg::*;

    logic [XLEN-1:0] logicout;
    logic [XLEN-1:0] shiftout;
    logic [XLEN-1:0] moveout;
    logic [XLEN-1:0] arithout;
    logic            src1_lt_src2;

    always_comb begin
        case (aluop_i)
            OP_OR:   logicout = src1_i | src2_i;
            OP_AND:  logicout = src1_i & src2_i;
            OP_XOR:  logicout = src1_i ^ src2_i;
            OP_NOR:  logicout = ~(src1_i | src2_i);
            default: logicout = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            OP_SLL:  shiftout = src1_i << src2_i[4:0];
            OP_SRL:  shiftout = src1_i >> src2_i[4:0];
            OP_SRA:  shiftout = $unsigned($signed(src1_i) >>> src2_i[4:0]);
            default: shiftout = '0;
        endcase
    end

    // SLT signed, SLTU unsigned
    assign src1_lt_src2 = (aluop_i == OP_SLT) ? ($signed(src1_i) < $signed(src2_i))
                                              : (src1_i < src2_i);

    always_comb begin
        case (aluop_i)
            OP_ADD:           arithout = src1_i + src2_i;
            OP_SUB:           arithout = src1_i - src2_i;
            OP_SLT, OP_SLTU:  arithout = {{(XLEN-1){1'b0}}, src1_lt_src2};
            default: begin
                // Multi-cycle result, valid once the unit has finished
                arithout = is_muldiv(aluop_i) ? muldiv_result_i : '0;
            end
        endcase
    end

    always_comb begin
        case (aluop_i)
            OP_LUI:   moveout = src2_i;
            OP_PCADD: moveout = pc_i + src2_i;
            default:  moveout = '0;
        endcase
    end

    always_comb begin
        case (res_sel_of(aluop_i))
            RES_LOGIC: wdata_o = logicout;
            RES_SHIFT: wdata_o = shiftout;
            RES_MOVE:  wdata_o = moveout;
            RES_ARITH: wdata_o = arithout;
            RES_JUMP:  wdata_o = pc_i + XLEN'(4);
            default:   wdata_o = '0;
        endcase
    end

endmodule

// File: logic/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
    input  logic [ex_pkg::XLEN-1:0]   oprand1_i,
    input  logic [ex_pkg::XLEN-1:0]   oprand2_i,
    input  logic [ex_pkg::XLEN-1:0]   imm_i,
    input  logic                      use_imm_i,
    input  logic [ex_pkg::REG_AW-1:0] read_addr1_i,
    input  logic [ex_pkg::REG_AW-1:0] read_addr2_i,
    input  logic                      fwd0_we_i,
    input  logic                      fwd0_load_i,
    input  logic [ex_pkg::REG_AW-1:0] fwd0_addr_i,
    input  logic [ex_pkg::XLEN-1:0]   fwd0_data_i,
    input  logic                      fwd1_we_i,
    input  logic                      fwd1_load_i,
    input  logic [ex_pkg::REG_AW-1:0] fwd1_addr_i,
    input  logic [ex_pkg::XLEN-1:0]   fwd1_data_i,
    output logic [ex_pkg::XLEN-1:0]   src1_o,
    output logic [ex_pkg::XLEN-1:0]   src2_o,
    output logic [ex_pkg::XLEN-1:0]   rs2_o
);

    logic hit1_a, hit0_a, hit1_b, hit0_b;

    // Only load data is forwarded here, r0 never
    assign hit1_a = fwd1_we_i && fwd1_load_i && (fwd1_addr_i == read_addr1_i) && (read_addr1_i != '0);
    assign hit0_a = fwd0_we_i && fwd0_load_i && (fwd0_addr_i == read_addr1_i) && (read_addr1_i != '0);
    assign hit1_b = fwd1_we_i && fwd1_load_i && (fwd1_addr_i == read_addr2_i) && (read_addr2_i != '0);
    assign hit0_b = fwd0_we_i && fwd0_load_i && (fwd0_addr_i == read_addr2_i) && (read_addr2_i != '0);

    // Slot 1 is younger
    assign src1_o = hit1_a ? fwd1_data_i : (hit0_a ? fwd0_data_i : oprand1_i);
    assign rs2_o  = hit1_b ? fwd1_data_i : (hit0_b ? fwd0_data_i : oprand2_i);

    assign src2_o = use_imm_i ? imm_i : rs2_o;

endmodule

// File: common/ex_pkg.sv
package ex_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef enum logic [5:0] {
        OP_OR, OP_AND, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
        OP_LUI, OP_PCADD,
        OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_MOD, OP_MODU,
        OP_B, OP_BL, OP_JIRL,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LD, OP_NOP
    } alu_op_e;

    typedef enum logic [2:0] {
        RES_LOGIC, RES_SHIFT, RES_MOVE, RES_ARITH, RES_JUMP, RES_NONE
    } res_sel_e;

    // Same encoding as the multi-cycle unit expects
    typedef enum logic [2:0] {
        MD_MUL   = 3'd0,
        MD_MULH  = 3'd1,
        MD_MULHU = 3'd3,
        MD_DIV   = 3'd4,
        MD_DIVU  = 3'd5,
        MD_MOD   = 3'd6,
        MD_MODU  = 3'd7
    } muldiv_mode_e;

    function automatic logic is_muldiv(alu_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
    endfunction

    function automatic res_sel_e res_sel_of(alu_op_e op);
        case (op)
            OP_OR, OP_AND, OP_XOR, OP_NOR:      return RES_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:             return RES_SHIFT;
            OP_LUI, OP_PCADD:                   return RES_MOVE;
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU:    return RES_ARITH;
            OP_BL, OP_JIRL:                     return RES_JUMP;
            default:                            return is_muldiv(op) ? RES_ARITH : RES_NONE;
        endcase
    endfunction

    function automatic muldiv_mode_e muldiv_mode_of(alu_op_e op);
        case (op)
            OP_MULH:  return MD_MULH;
            OP_MULHU: return MD_MULHU;
            OP_DIV:   return MD_DIV;
            OP_DIVU:  return MD_DIVU;
            OP_MOD:   return MD_MOD;
            OP_MODU:  return MD_MODU;
            default:  return MD_MUL;
        endcase
    endfunction

endpackage
